// File: debrisField.sv
`timescale 1ns/1ps
`default_nettype none
`include "robotController_settings.svh"

module debrisField import robotControllerPkg::*; (
    input  logic Clock50,
    input  logic reset,
    input  logic placeLight,
    input  logic placeMedium,
    input  logic placeHeavy,
    input  logic senseStrobe,
    input  logic moveGo,
    input  logic remover,
    input  logic aheadInside,
    input  rowT  cursorRow,
    input  colT  cursorCol,
    input  rowT  aheadRow,
    input  colT  aheadCol,
    output rowT  lightRow,
    output colT  lightCol,
    output rowT  mediumRow,
    output colT  mediumCol,
    output rowT  heavyRow,
    output colT  heavyCol,
    output logic barrierAhead
);

    // Index 0 is light, 1 medium, 2 heavy
    localparam rowT  StartRow [3] = '{rowT'(`NoRow), rowT'(`ResetMediumRow), rowT'(`ResetHeavyRow)};
    localparam colT  StartCol [3] = '{colT'(`NoCol), colT'(`ResetMediumCol), colT'(`ResetHeavyCol)};
    localparam lifeT PieceLife [3] = '{lifeT'(`LifeLight), lifeT'(`LifeMedium), lifeT'(`LifeHeavy)};

    rowT        pieceRow [3];
    colT        pieceCol [3];
    logic [2:0] place;
    logic [2:0] hit;
    logic [1:0] matchIdx;
    lifeT       life;
    logic       removeDone;

    assign place = {placeHeavy, placeMedium, placeLight};

    // Lightest matching piece wins
    always_comb begin
        matchIdx = 2'd0;
        for (int i = 2; i >= 0; i--) begin
            hit[i] = aheadInside && (pieceRow[i] == aheadRow) && (pieceCol[i] == aheadCol);
            if (hit[i]) begin
                matchIdx = 2'(i);
            end
        end
    end

    assign barrierAhead = |hit;
    assign removeDone   = moveGo && remover && (life == lifeT'(1)) && barrierAhead;

    always_ff @(posedge Clock50) begin
        if (reset) begin
            life <= '0;
            for (int i = 0; i < 3; i++) begin
                pieceRow[i] <= StartRow[i];
                pieceCol[i] <= StartCol[i];
            end
        end else begin
            if (senseStrobe && barrierAhead && life == '0) begin
                life <= PieceLife[matchIdx];
            end else if (moveGo && remover && life != '0) begin
                life <= life - lifeT'(1);
            end
            for (int i = 0; i < 3; i++) begin
                if (removeDone && matchIdx == 2'(i)) begin
                    pieceRow[i] <= rowT'(`NoRow);
                    pieceCol[i] <= colT'(`NoCol);
                end else if (place[i] && pieceRow[i] == rowT'(`NoRow)
                             && pieceCol[i] == colT'(`NoCol)) begin
                    pieceRow[i] <= cursorRow;
                    pieceCol[i] <= cursorCol;
                end
            end
        end
    end

    assign lightRow  = pieceRow[0];
    assign lightCol  = pieceCol[0];
    assign mediumRow = pieceRow[1];
    assign mediumCol = pieceCol[1];
    assign heavyRow  = pieceRow[2];
    assign heavyCol  = pieceCol[2];

endmodule

`default_nettype wire

// File: filelist.f
+incdir+.
robotControllerPkg.sv
frameTimer.sv
mazeMap.sv
operatorPanel.sv
debrisField.sv
robotCore.sv
robotController.sv
tb_robotController.sv

// File: frameTimer.sv
`timescale 1ns/1ps
`default_nettype none
`include "robotController_settings.svh"

module frameTimer (
    input  logic Clock50,
    input  logic reset,
    input  logic vsync,
    output logic scanStrobe,
    output logic senseStrobe,
    output logic moveStrobe,
    output logic robotActive
);

    // Two synchronizer stages and one more for the edge detect
    logic vsyncMeta;
    logic vsyncSync;
    logic vsyncPrev;
    logic tick;

    logic [2:0] scanCount;
    logic [3:0] robotCount;
    // High once the first robot period has passed
    logic robotArmed;

    always_ff @(posedge Clock50) begin
        if (reset) begin
            vsyncMeta <= 1'b0;
            vsyncSync <= 1'b0;
            vsyncPrev <= 1'b0;
        end else begin
            vsyncMeta <= vsync;
            vsyncSync <= vsyncMeta;
            vsyncPrev <= vsyncSync;
        end
    end

    assign tick = vsyncSync & ~vsyncPrev;

    // Counters hold the number of ticks seen so far, modulo the period
    assign scanStrobe  = tick & (scanCount == 3'd0);
    assign senseStrobe = tick & robotArmed & (robotCount == 4'd0);
    assign moveStrobe  = tick & robotActive;

    always_ff @(posedge Clock50) begin
        if (reset) begin
            scanCount   <= 3'd0;
            robotCount  <= 4'd0;
            robotArmed  <= 1'b0;
            robotActive <= 1'b0;
        end else begin
            if (tick) begin
                if (scanCount == 3'(`ScanPeriod - 1)) begin
                    scanCount <= 3'd0;
                end else begin
                    scanCount <= scanCount + 3'd1;
                end
                if (robotCount == 4'(`RobotPeriod - 1)) begin
                    robotCount <= 4'd0;
                    robotArmed <= 1'b1;
                end else begin
                    robotCount <= robotCount + 4'd1;
                end
            end
            // Active from the sense tick up to the following move tick
            if (senseStrobe) begin
                robotActive <= 1'b1;
            end else if (moveStrobe) begin
                robotActive <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// File: mazeMap.sv
`timescale 1ns/1ps
`default_nettype none
`include "robotController_settings.svh"

module mazeMap import robotControllerPkg::*; (
    input  rowT  cursorRow,
    input  colT  cursorCol,
    input  rowT  headRow,
    input  colT  headCol,
    input  rowT  leftRow,
    input  colT  leftCol,
    output cellT cursorCell,
    output cellT headCell,
    output cellT leftCell
);

    // One hex digit per cell with column 0 in the top digit
    localparam logic [`MapCols*4-1:0] MapTable [`MapRows] = '{
        80'h55555555555555555555,
        80'h56665666666666665555,
        80'h56565656555555565555,
        80'h56565656666666666665,
        80'h56565656555555565555,
        80'h56566656555555565555,
        80'h56565556555555565555,
        80'h56565556555555565555,
        80'h56565556555555565555,
        80'h56666666666666665555
    };

    // Anything off the map reads as wall
    function automatic cellT cellAt(input rowT row, input colT col);
        logic [`MapCols*4-1:0] rowBits;
        if (row >= rowT'(`MapRows) || col >= colT'(`MapCols)) begin
            return cellT'(`CellWall);
        end
        rowBits = MapTable[row];
        return rowBits[(`MapCols - 1 - int'(col)) * 4 +: 4];
    endfunction

    assign cursorCell = cellAt(cursorRow, cursorCol);
    assign headCell   = cellAt(headRow, headCol);
    assign leftCell   = cellAt(leftRow, leftCol);

endmodule

`default_nettype wire

// File: operatorPanel.sv
`timescale 1ns/1ps
`default_nettype none
`include "robotController_settings.svh"

module operatorPanel import robotControllerPkg::*; (
    input  logic Clock50,
    input  logic reset,
    input  logic scanStrobe,
    input  logic moveStrobe,
    input  padT  pad,
    input  cellT cursorCell,
    output rowT  cursorRow,
    output colT  cursorCol,
    output rowT  blackRow,
    output colT  blackCol,
    output logic placeRobot,
    output logic placeLight,
    output logic placeMedium,
    output logic placeHeavy,
    output logic moveGo
);

    logic stepMode;
    logic stepPending;
    logic cursorFree;
    logic cursorOnBlack;
    logic stepTaken;

    assign cursorFree    = (cursorCell == cellT'(`CellFree));
    assign cursorOnBlack = (cursorRow == blackRow) && (cursorCol == blackCol);

    // Placement requests use the cursor as it stood before this scan
    assign placeRobot  = scanStrobe & pad[`PadPlaceRobot] & (cursorFree | cursorOnBlack);
    assign placeLight  = scanStrobe & pad[`PadLight] & cursorFree;
    assign placeMedium = scanStrobe & pad[`PadMedium] & cursorFree;
    assign placeHeavy  = scanStrobe & pad[`PadHeavy] & cursorFree;

    // In step mode each Step press lets exactly one move through
    assign stepTaken = moveStrobe & stepMode & stepPending;
    assign moveGo    = moveStrobe & (~stepMode | stepPending);

    always_ff @(posedge Clock50) begin
        if (reset) begin
            cursorRow   <= rowT'(`ResetCursorRow);
            cursorCol   <= colT'(`ResetCursorCol);
            blackRow    <= rowT'(`ResetRobotRow);
            blackCol    <= colT'(`ResetRobotCol);
            stepMode    <= 1'b0;
            stepPending <= 1'b0;
        end else begin
            if (scanStrobe) begin
                // Down beats Up, Right beats Left
                if (pad[`PadDown]) begin
                    cursorRow <= (cursorRow == rowT'(`MapRows - 1)) ? '0 : cursorRow + rowT'(1);
                end else if (pad[`PadUp]) begin
                    cursorRow <= (cursorRow == '0) ? rowT'(`MapRows - 1) : cursorRow - rowT'(1);
                end
                if (pad[`PadRight]) begin
                    cursorCol <= (cursorCol == colT'(`MapCols - 1)) ? '0 : cursorCol + colT'(1);
                end else if (pad[`PadLeft]) begin
                    cursorCol <= (cursorCol == '0) ? colT'(`MapCols - 1) : cursorCol - colT'(1);
                end
                if (pad[`PadPlaceBlack] && cursorFree) begin
                    blackRow <= cursorRow;
                    blackCol <= cursorCol;
                end
                if (pad[`PadStepMode]) begin
                    stepMode <= ~stepMode;
                end
            end
            // A move consuming the request beats a new press on the same tick
            if (stepTaken) begin
                stepPending <= 1'b0;
            end else if (scanStrobe && pad[`PadStep] && stepMode) begin
                stepPending <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: robotController.sv
`timescale 1ns/1ps
`default_nettype none

module robotController import robotControllerPkg::*; (
    input  logic        Clock50,
    input  logic        reset,
    input  logic        vsync,
    input  logic        avancar,
    input  logic        girar,
    input  logic        remover,
    input  padT         pad,
    output logic        head,
    output logic        left,
    output logic        under,
    output logic        barrier,
    output logic        robotActive,
    output logic [29:0] spriteCols,
    output logic [23:0] spriteRows,
    output headingT     heading
);

    logic scanStrobe;
    logic senseStrobe;
    logic moveStrobe;
    logic moveGo;
    logic placeRobot;
    logic placeLight;
    logic placeMedium;
    logic placeHeavy;
    logic aheadInside;
    logic barrierAhead;
    rowT  cursorRow, blackRow, robotRow, aheadRow, leftRow;
    colT  cursorCol, blackCol, robotCol, aheadCol, leftCol;
    rowT  lightRow, mediumRow, heavyRow;
    colT  lightCol, mediumCol, heavyCol;
    cellT cursorCell, headCell, leftCell;

    frameTimer timer_i (.Clock50, .reset, .vsync, .scanStrobe, .senseStrobe, .moveStrobe,
                        .robotActive);

    mazeMap map_i (.cursorRow, .cursorCol, .headRow(aheadRow), .headCol(aheadCol), .leftRow,
                   .leftCol, .cursorCell, .headCell, .leftCell);

    operatorPanel panel_i (.Clock50, .reset, .scanStrobe, .moveStrobe, .pad, .cursorCell,
                           .cursorRow, .cursorCol, .blackRow, .blackCol, .placeRobot,
                           .placeLight, .placeMedium, .placeHeavy, .moveGo);

    debrisField debris_i (.Clock50, .reset, .placeLight, .placeMedium, .placeHeavy,
                          .senseStrobe, .moveGo, .remover, .aheadInside, .cursorRow,
                          .cursorCol, .aheadRow, .aheadCol, .lightRow, .lightCol, .mediumRow,
                          .mediumCol, .heavyRow, .heavyCol, .barrierAhead);

    robotCore core_i (.Clock50, .reset, .senseStrobe, .moveGo, .placeRobot, .avancar, .girar,
                      .barrierAhead, .cursorRow, .cursorCol, .blackRow, .blackCol, .headCell,
                      .leftCell, .robotRow, .robotCol, .aheadRow, .aheadCol, .leftRow,
                      .leftCol, .heading, .aheadInside, .head, .left, .under, .barrier);

    // Black cell in the top field, cursor in the bottom one
    assign spriteCols = {blackCol, lightCol, mediumCol, heavyCol, robotCol, cursorCol};
    assign spriteRows = {blackRow, lightRow, mediumRow, heavyRow, robotRow, cursorRow};

endmodule

`default_nettype wire

// File: robotControllerPkg.sv
`default_nettype none

package robotControllerPkg;

    typedef logic [3:0] rowT;
    typedef logic [4:0] colT;
    typedef logic [3:0] cellT;

    // Remaining remove ticks of the debris in front of the robot
    typedef logic [3:0] lifeT;

    typedef logic [11:0] padT;

    typedef enum logic [1:0] {
        North = 2'd0,
        South = 2'd1,
        East  = 2'd2,
        West  = 2'd3
    } headingT;

endpackage

`default_nettype wire

// File: robotController_settings.svh
`ifndef ROBOT_CONTROLLER_SETTINGS_SVH
`define ROBOT_CONTROLLER_SETTINGS_SVH

// Map geometry and cell codes
`define MapRows 10
`define MapCols 20
`define CellFree 6
`define CellWall 5

// Off-map position of a debris piece that is absent
`define NoRow 15
`define NoCol 31

// Positions after reset
// The black cell starts under the robot
`define ResetRobotRow 3
`define ResetRobotCol 18
`define ResetCursorRow 3
`define ResetCursorCol 10
`define ResetMediumRow 5
`define ResetMediumCol 15
`define ResetHeavyRow 3
`define ResetHeavyCol 17

// Frame periods in vsync ticks
`define ScanPeriod 5
`define RobotPeriod 9

// Remove ticks needed per debris weight
`define LifeLight 3
`define LifeMedium 6
`define LifeHeavy 9

// Gamepad bit positions
`define PadUp 0
`define PadDown 1
`define PadLeft 2
`define PadRight 3
`define PadPlaceRobot 4
`define PadPlaceBlack 5
`define PadStepMode 6
`define PadLight 7
`define PadMedium 8
`define PadHeavy 9
`define PadStep 10

`endif

// File: robotCore.sv
`timescale 1ns/1ps
`default_nettype none
`include "robotController_settings.svh"

module robotCore import robotControllerPkg::*; (
    input  logic    Clock50,
    input  logic    reset,
    input  logic    senseStrobe,
    input  logic    moveGo,
    input  logic    placeRobot,
    input  logic    avancar,
    input  logic    girar,
    input  logic    barrierAhead,
    input  rowT     cursorRow,
    input  colT     cursorCol,
    input  rowT     blackRow,
    input  colT     blackCol,
    input  cellT    headCell,
    input  cellT    leftCell,
    output rowT     robotRow,
    output colT     robotCol,
    output rowT     aheadRow,
    output colT     aheadCol,
    output rowT     leftRow,
    output colT     leftCol,
    output headingT heading,
    output logic    aheadInside,
    output logic    head,
    output logic    left,
    output logic    under,
    output logic    barrier
);

    headingT leftHeading;
    logic    leftInside;

    // Also the result of a left turn
    function automatic headingT leftOf(input headingT dir);
        case (dir)
            North:   return West;
            West:    return South;
            South:   return East;
            default: return North;
        endcase
    endfunction

    function automatic rowT stepRow(input headingT dir, input rowT row);
        case (dir)
            North:   return row - rowT'(1);
            South:   return row + rowT'(1);
            default: return row;
        endcase
    endfunction

    function automatic colT stepCol(input headingT dir, input colT col);
        case (dir)
            East:    return col + colT'(1);
            West:    return col - colT'(1);
            default: return col;
        endcase
    endfunction

    // False when the step would leave the map
    function automatic logic stepInside(input headingT dir, input rowT row, input colT col);
        case (dir)
            North:   return row != '0;
            South:   return row != rowT'(`MapRows - 1);
            East:    return col != colT'(`MapCols - 1);
            default: return col != '0;
        endcase
    endfunction

    assign leftHeading = leftOf(heading);
    assign aheadRow    = stepRow(heading, robotRow);
    assign aheadCol    = stepCol(heading, robotCol);
    assign aheadInside = stepInside(heading, robotRow, robotCol);
    assign leftRow     = stepRow(leftHeading, robotRow);
    assign leftCol     = stepCol(leftHeading, robotCol);
    assign leftInside  = stepInside(leftHeading, robotRow, robotCol);

    always_ff @(posedge Clock50) begin
        if (reset) begin
            robotRow <= rowT'(`ResetRobotRow);
            robotCol <= colT'(`ResetRobotCol);
            heading  <= East;
            head     <= 1'b0;
            left     <= 1'b0;
            under    <= 1'b0;
            barrier  <= 1'b0;
        end else begin
            if (senseStrobe) begin
                head    <= ~aheadInside | (headCell == cellT'(`CellWall));
                left    <= ~leftInside | (leftCell == cellT'(`CellWall));
                under   <= (robotRow == blackRow) && (robotCol == blackCol);
                barrier <= barrierAhead;
            end
            // Motion beats a placement landing on the same tick
            if (moveGo) begin
                if (avancar) begin
                    robotRow <= aheadRow;
                    robotCol <= aheadCol;
                end else if (girar) begin
                    heading <= leftHeading;
                end
            end else if (placeRobot) begin
                robotRow <= cursorRow;
                robotCol <= cursorCol;
            end
        end
    end

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing -f filelist.f --top-module tb_robotController -o simRobot &&
./obj_dir/simRobot ||
{ echo "build or simulation failed"; exit 1; }

// File: tb_robotController.sv
`timescale 1ns/1ps
`default_nettype none
`include "robotController_settings.svh"

module tb_robotController import robotControllerPkg::*; ();

    // Two synchronizer stages between the vsync rise and the tick
    localparam int TickTimeout = 2;
    localparam int DirectedTicks = 105;
    localparam int LastTick = 700;

    logic        Clock50;
    logic        reset;
    logic        vsync;
    logic        avancar;
    logic        girar;
    logic        remover;
    padT         pad;
    logic        head;
    logic        left;
    logic        under;
    logic        barrier;
    logic        robotActive;
    logic [29:0] spriteCols;
    logic [23:0] spriteRows;
    headingT     heading;

    int    seed = 32'h2416;
    string testName;

    // Reference model state with headings coded as in headingT
    int mTick;
    int mCurRow;
    int mCurCol;
    int mBlackRow;
    int mBlackCol;
    int mRobotRow;
    int mRobotCol;
    int mHeading;
    int mPieceRow [3];
    int mPieceCol [3];
    int mLife;
    bit mStepMode;
    bit mStepPending;
    bit mActive;
    bit mHead;
    bit mLeft;
    bit mUnder;
    bit mBarrier;

    // Maze layout where # marks a wall
    string maze [`MapRows] = '{
        "####################",
        "#...#...........####",
        "#.#.#.#.#######.####",
        "#.#.#.#............#",
        "#.#.#.#.#######.####",
        "#.#...#.#######.####",
        "#.#.###.#######.####",
        "#.#.###.#######.####",
        "#.#.###.#######.####",
        "#...............####"
    };

    robotController dut_i (.Clock50, .reset, .vsync, .avancar, .girar, .remover, .pad, .head,
                           .left, .under, .barrier, .robotActive, .spriteCols, .spriteRows,
                           .heading);

    initial begin
        Clock50 = 1'b0;
        forever #20 Clock50 = ~Clock50;
    end

    // Off the map counts as wall
    function automatic bit isWall(input int row, input int col);
        string line;
        if (row < 0 || row >= `MapRows || col < 0 || col >= `MapCols) begin
            return 1'b1;
        end
        line = maze[row];
        return line[col] == "#";
    endfunction

    function automatic int stepRow(input int dir, input int row);
        return (dir == 0) ? row - 1 : (dir == 1) ? row + 1 : row;
    endfunction

    function automatic int stepCol(input int dir, input int col);
        return (dir == 2) ? col + 1 : (dir == 3) ? col - 1 : col;
    endfunction

    function automatic int turnLeft(input int dir);
        case (dir)
            0: return 3;
            3: return 1;
            1: return 2;
            default: return 0;
        endcase
    endfunction

    function automatic int lifeOf(input int piece);
        return (piece == 0) ? `LifeLight : (piece == 1) ? `LifeMedium : `LifeHeavy;
    endfunction

    // Lightest piece on the given cell or -1 when none
    function automatic int matchedPiece(input int row, input int col);
        for (int i = 0; i < 3; i++) begin
            if (!isWall(row, col) && mPieceRow[i] == row && mPieceCol[i] == col) begin
                return i;
            end
        end
        return -1;
    endfunction

    function automatic bit aheadClear();
        int r;
        int c;
        r = stepRow(mHeading, mRobotRow);
        c = stepCol(mHeading, mRobotCol);
        return !isWall(r, c) && matchedPiece(r, c) < 0;
    endfunction

    // Sparse button presses
    function automatic padT randomPad();
        padT p;
        p = '0;
        for (int b = 0; b <= `PadStep; b++) begin
            p[b] = ($random(seed) & 7) == 0;
        end
        return p;
    endfunction

    // Cursor walk with both wraps and the Up plus Down case
    function automatic padT directedPad(input int tick);
        padT p;
        p = '0;
        if (tick == 1) begin
            p[`PadUp] = 1'b1;
            p[`PadDown] = 1'b1;
            p[`PadLeft] = 1'b1;
            p[`PadRight] = 1'b1;
        end else if (tick >= 6 && tick <= 26) begin
            p[`PadUp] = 1'b1;
        end else if (tick >= 31 && tick <= 86) begin
            p[`PadLeft] = 1'b1;
        end
        return p;
    endfunction

    task automatic abortRun();
        $display("Simulation failed");
        $fatal(1, "run stopped on error");
    endtask

    task automatic checkValue(input string what, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (expected !== actual) begin
            $display("MISMATCH %s %s expected %0h actual %0h", testName, what, expected,
                     actual);
            abortRun();
        end
    endtask

    task automatic resetModel();
        mTick = 0;
        mCurRow = `ResetCursorRow;
        mCurCol = `ResetCursorCol;
        mBlackRow = `ResetRobotRow;
        mBlackCol = `ResetRobotCol;
        mRobotRow = `ResetRobotRow;
        mRobotCol = `ResetRobotCol;
        mHeading = 2;
        mPieceRow = '{`NoRow, `ResetMediumRow, `ResetHeavyRow};
        mPieceCol = '{`NoCol, `ResetMediumCol, `ResetHeavyCol};
        mLife = 0;
        mStepMode = 1'b0;
        mStepPending = 1'b0;
        mActive = 1'b0;
        mHead = 1'b0;
        mLeft = 1'b0;
        mUnder = 1'b0;
        mBarrier = 1'b0;
    endtask

    // One vsync tick with all decisions taken from the state before it
    task automatic modelTick(input padT p, input bit av, input bit gi, input bit rm);
        bit scan;
        bit sense;
        bit moveStrobe;
        bit moveGo;
        bit cursorFree;
        bit placeRobot;
        bit removeDone;
        int aheadR;
        int aheadC;
        int leftDir;
        int hit;
        mTick++;
        scan = ((mTick - 1) % `ScanPeriod) == 0;
        sense = mTick > `RobotPeriod && ((mTick - `RobotPeriod - 1) % `RobotPeriod) == 0;
        moveStrobe = mActive;
        moveGo = moveStrobe && (!mStepMode || mStepPending);
        cursorFree = !isWall(mCurRow, mCurCol);
        placeRobot = scan && p[`PadPlaceRobot]
                     && (cursorFree || (mCurRow == mBlackRow && mCurCol == mBlackCol));
        aheadR = stepRow(mHeading, mRobotRow);
        aheadC = stepCol(mHeading, mRobotCol);
        leftDir = turnLeft(mHeading);
        hit = matchedPiece(aheadR, aheadC);
        removeDone = moveGo && rm && mLife == 1 && hit >= 0;

        if (sense) begin
            mHead = isWall(aheadR, aheadC);
            mLeft = isWall(stepRow(leftDir, mRobotRow), stepCol(leftDir, mRobotCol));
            mUnder = mRobotRow == mBlackRow && mRobotCol == mBlackCol;
            mBarrier = hit >= 0;
        end
        if (sense && hit >= 0 && mLife == 0) begin
            mLife = lifeOf(hit);
        end else if (moveGo && rm && mLife != 0) begin
            mLife--;
        end
        for (int i = 0; i < 3; i++) begin
            if (removeDone && hit == i) begin
                mPieceRow[i] = `NoRow;
                mPieceCol[i] = `NoCol;
            end else if (scan && p[`PadLight + i] && cursorFree
                         && mPieceRow[i] == `NoRow && mPieceCol[i] == `NoCol) begin
                mPieceRow[i] = mCurRow;
                mPieceCol[i] = mCurCol;
            end
        end
        if (moveGo) begin
            if (av) begin
                mRobotRow = aheadR;
                mRobotCol = aheadC;
            end else if (gi) begin
                mHeading = leftDir;
            end
        end else if (placeRobot) begin
            mRobotRow = mCurRow;
            mRobotCol = mCurCol;
        end
        if (scan && p[`PadPlaceBlack] && cursorFree) begin
            mBlackRow = mCurRow;
            mBlackCol = mCurCol;
        end
        if (moveStrobe && mStepMode && mStepPending) begin
            mStepPending = 1'b0;
        end else if (scan && p[`PadStep] && mStepMode) begin
            mStepPending = 1'b1;
        end
        if (scan && p[`PadStepMode]) begin
            mStepMode = !mStepMode;
        end
        if (scan) begin
            if (p[`PadDown]) begin
                mCurRow = (mCurRow + 1) % `MapRows;
            end else if (p[`PadUp]) begin
                mCurRow = (mCurRow + `MapRows - 1) % `MapRows;
            end
            if (p[`PadRight]) begin
                mCurCol = (mCurCol + 1) % `MapCols;
            end else if (p[`PadLeft]) begin
                mCurCol = (mCurCol + `MapCols - 1) % `MapCols;
            end
        end
        if (sense) begin
            mActive = 1'b1;
        end else if (moveStrobe) begin
            mActive = 1'b0;
        end
    endtask

    task automatic compareOutputs();
        logic [23:0] expRows;
        logic [29:0] expCols;
        expRows = {4'(mBlackRow), 4'(mPieceRow[0]), 4'(mPieceRow[1]), 4'(mPieceRow[2]),
                   4'(mRobotRow), 4'(mCurRow)};
        expCols = {5'(mBlackCol), 5'(mPieceCol[0]), 5'(mPieceCol[1]), 5'(mPieceCol[2]),
                   5'(mRobotCol), 5'(mCurCol)};
        checkValue("spriteRows", 32'(expRows), 32'(spriteRows));
        checkValue("spriteCols", 32'(expCols), 32'(spriteCols));
        checkValue("heading", 32'(mHeading), 32'(heading));
        checkValue("head", 32'(mHead), 32'(head));
        checkValue("left", 32'(mLeft), 32'(left));
        checkValue("under", 32'(mUnder), 32'(under));
        checkValue("barrier", 32'(mBarrier), 32'(barrier));
        checkValue("robotActive", 32'(mActive), 32'(robotActive));
    endtask

    // Vsync high 4 cycles then low 4 with outputs checked 4 cycles after the rise
    task automatic runFrame(input padT p, input bit av, input bit gi, input bit rm);
        int waited;
        pad = p;
        avancar = av;
        girar = gi;
        remover = rm;
        vsync = 1'b1;
        waited = 0;
        while (dut_i.timer_i.tick !== 1'b1) begin
            if (waited == TickTimeout) begin
                $display("Timeout: no vsync tick seen for frame %0d", mTick + 1);
                abortRun();
            end else begin
                @(posedge Clock50);
                #2;
                waited++;
            end
        end
        modelTick(p, av, gi, rm);
        repeat (2) @(posedge Clock50);
        #2;
        compareOutputs();
        vsync = 1'b0;
        repeat (4) @(posedge Clock50);
        #2;
    endtask

    initial begin
        padT p;
        bit  av;
        bit  gi;
        bit  rm;
        bit  go;
        reset = 1'b1;
        vsync = 1'b0;
        avancar = 1'b0;
        girar = 1'b0;
        remover = 1'b0;
        pad = '0;
        resetModel();
        repeat (2) @(posedge Clock50);
        #2;
        reset = 1'b0;
        testName = "reset";
        compareOutputs();

        // Turn west to face the heavy piece, then hold remover
        testName = "directed";
        while (mTick < DirectedTicks) begin
            runFrame(directedPad(mTick + 1), 1'b0, mTick + 1 < 25, mTick + 1 >= 25);
        end
        checkValue("heavyRow parked", `NoRow, 32'(spriteRows[11:8]));
        checkValue("heavyCol parked", `NoCol, 32'(spriteCols[14:10]));

        testName = "random";
        while (mTick < LastTick) begin
            p = randomPad();
            gi = ($random(seed) & 1) == 1;
            go = ($random(seed) & 3) != 0;
            rm = ($random(seed) & 3) == 0;
            // Advance only into a free cell so the robot stays on the map
            av = go && aheadClear();
            runFrame(p, av, gi, rm);
        end
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

`default_nettype wire
